//--- filelist.f
+incdir+include
source/spi_bridge_pkg.sv
source/spi_bit_counter.sv
source/spi_shifter.sv
source/spi_cmd_fsm.sv
source/wb_requester.sv
source/bridge_ram.sv
source/spi_ram_bridge.sv
testbench/tb_spi_ram_bridge.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the SPI to RAM bridge testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    -f filelist.f \
    --top-module tb_spi_ram_bridge \
    -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "Regression passed" sim.log; then
    echo "Simulation PASSED"
    exit 0
else
    echo "Simulation FAILED"
    exit 1
fi

//--- source/bridge_ram.sv
//**********************************************************************
// 4096 byte RAM on the bridge bus
// Acknowledges every strobe one cycle later, writing or reading then
//**********************************************************************
`timescale 1ns/10ps

module bridge_ram (
    input  logic                                spi_cs_ni,
    input  logic                                spi_sck_i,
    input  logic                                cyc_i,
    input  logic                                stb_i,
    input  spi_bridge_pkg::bus_req_s            bus_i,
    output logic                                ack_o,
    output logic [spi_bridge_pkg::DATA_W-1:0]   rdata_o
);
    import spi_bridge_pkg::*;

    logic [DATA_W-1:0] mem [2**ADDR_W];
    logic              req;

    assign req = cyc_i & stb_i;

    always_ff @(posedge spi_cs_ni or posedge spi_sck_i) begin
        if (spi_sck_i) begin
            ack_o <= 1'b0;
            mem   <= '{default: '0};  // Memory reads zero after reset
        end else begin
            ack_o <= req;
            if (req && bus_i.we) mem[bus_i.addr] <= bus_i.wdata;
        end
    end

    always_ff @(posedge spi_cs_ni) begin
        if (req && !bus_i.we) rdata_o <= mem[bus_i.addr];  // Valid with ack
    end

endmodule

//--- source/spi_bit_counter.sv
//**********************************************************************
// Samples the serial clock and chip select in the system clock domain
// Gives one-cycle pulses for sclk edges and for each completed byte
//**********************************************************************
`timescale 1ns/10ps

module spi_bit_counter (
    input  logic spi_cs_ni,   // System clock
    input  logic spi_sck_i,   // Async reset, active high
    input  logic sclk_i,      // Serial clock as data
    input  logic csn_i,       // Serial chip select, active low
    output logic rise_o,      // Synchronised sclk rising edge
    output logic fall_o,      // Synchronised sclk falling edge
    output logic sel_o,       // High while selected
    output logic byte_done_o  // Rise that completes eight bits
);
    import spi_bridge_pkg::*;

    logic [SYNC_STAGES-1:0] sclk_sync;
    logic [SYNC_STAGES-1:0] csn_sync;
    logic                   sclk_q;   // Previous synchronised sclk
    logic [BIT_CNT_W-1:0]   bit_cnt;
    logic                   sclk_s;

    assign sclk_s = sclk_sync[SYNC_STAGES-1];
    assign sel_o  = ~csn_sync[SYNC_STAGES-1];

    always_ff @(posedge spi_cs_ni or posedge spi_sck_i) begin
        if (spi_sck_i) begin
            sclk_sync <= '0;
            csn_sync  <= '1;  // Deselected out of reset
            sclk_q    <= 1'b0;
        end else begin
            sclk_sync <= {sclk_sync[SYNC_STAGES-2:0], sclk_i};
            csn_sync  <= {csn_sync[SYNC_STAGES-2:0], csn_i};
            sclk_q    <= sclk_s;
        end
    end

    // Edges only count inside a frame
    assign rise_o = sel_o & sclk_s & ~sclk_q;
    assign fall_o = sel_o & ~sclk_s & sclk_q;

    always_ff @(posedge spi_cs_ni or posedge spi_sck_i) begin
        if (spi_sck_i) begin
            bit_cnt <= '0;
        end else if (!sel_o) begin
            bit_cnt <= '0;  // Realign at each frame
        end else if (rise_o) begin
            bit_cnt <= bit_cnt + 1'b1;  // Wraps after the eighth bit
        end
    end

    assign byte_done_o = rise_o && (bit_cnt == BIT_CNT_W'(7));

    a_edges_exclusive: assert property (
        @(posedge spi_cs_ni) disable iff (spi_sck_i) !(rise_o && fall_o));

endmodule

//--- source/spi_bridge_pkg.sv
//**********************************************************************
// Shared widths and types for the SPI to RAM bridge
// Holds the frame FSM states, the command byte layout, the received
// byte view and the bus request carried from the FSM to the bus side
//**********************************************************************
package spi_bridge_pkg;

    localparam int ADDR_W      = 12; // Bus address, 4096 bytes
    localparam int DATA_W      = 8;  // Bus data
    localparam int BIT_CNT_W   = 3;  // Counts eight bits per byte
    localparam int SYNC_STAGES = 2;  // Input synchroniser depth

    // Frame FSM, one state per expected byte
    typedef enum logic [2:0] {
        st_cmd,     // Waiting for the command byte
        st_data,    // Write data byte
        st_addr_lo, // Low address byte
        st_valid,   // Request issued this cycle
        st_done     // Idle until chip select drops
    } cmd_state_e;

    // Command byte, MSB first on the wire
    typedef struct packed {
        logic       we;       // 1 = write
        logic       set_addr; // 1 = low address byte follows
        logic [1:0] rsvd;     // Ignored
        logic [3:0] addr_hi;  // Upper address bits
    } cmd_fields_s;

    // Received byte seen raw or as a command
    typedef union packed {
        logic [DATA_W-1:0] raw;
        cmd_fields_s       cmd;
    } spi_byte_u;

    // One pending bus transfer
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic              we;
    } bus_req_s;

endpackage

//--- source/spi_cmd_fsm.sv
//**********************************************************************
// Frame decoder for the SPI bridge
// Walks command, optional data and optional low address bytes, then
// issues one bus request per frame and waits for chip select to drop
//**********************************************************************
`timescale 1ns/10ps

module spi_cmd_fsm (
    input  logic                        spi_cs_ni,
    input  logic                        spi_sck_i,
    input  logic                        sel_i,
    input  logic                        byte_done_i,
    input  spi_bridge_pkg::spi_byte_u   rx_byte_i,
    output logic                        req_valid_o, // One cycle on entering st_valid
    output spi_bridge_pkg::bus_req_s    req_o
);
    import spi_bridge_pkg::*;

    cmd_state_e        state;
    cmd_fields_s       cmd_q;     // Command of the current frame
    logic [ADDR_W-1:0] addr_inc;  // Previous address plus one, wraps at 4096

    assign addr_inc = req_o.addr + 1'b1;

    always_ff @(posedge spi_cs_ni or posedge spi_sck_i) begin
        if (spi_sck_i) begin
            state       <= st_cmd;
            cmd_q       <= '0;
            req_valid_o <= 1'b0;
            req_o       <= '0;  // Address starts at zero
        end else begin
            req_valid_o <= 1'b0;
            if (!sel_i) begin
                state <= st_cmd;  // Deselect ends or aborts the frame
            end else begin
                unique case (state)
                    st_cmd: begin
                        if (byte_done_i) begin
                            cmd_q    <= rx_byte_i.cmd;
                            req_o.we <= rx_byte_i.cmd.we;
                            if (rx_byte_i.cmd.we) begin
                                state <= st_data;
                            end else if (rx_byte_i.cmd.set_addr) begin
                                state <= st_addr_lo;
                            end else begin
                                state       <= st_valid;  // Read at next address
                                req_valid_o <= 1'b1;
                                req_o.addr  <= addr_inc;
                            end
                        end
                    end
                    st_data: begin
                        if (byte_done_i) begin
                            req_o.wdata <= rx_byte_i.raw;
                            if (cmd_q.set_addr) begin
                                state <= st_addr_lo;
                            end else begin
                                state       <= st_valid;
                                req_valid_o <= 1'b1;
                                req_o.addr  <= addr_inc;
                            end
                        end
                    end
                    st_addr_lo: begin
                        if (byte_done_i) begin
                            state       <= st_valid;
                            req_valid_o <= 1'b1;
                            req_o.addr  <= {cmd_q.addr_hi, rx_byte_i.raw};
                        end
                    end
                    st_valid: state <= st_done;
                    st_done:  state <= st_done;  // Extra bytes are ignored
                    default:  state <= st_cmd;
                endcase
            end
        end
    end

    // Only one request until the frame is released
    a_one_req_per_frame: assert property (
        @(posedge spi_cs_ni) disable iff (spi_sck_i)
        req_valid_o |=> (!req_valid_o until !sel_i));

endmodule

//--- source/spi_ram_bridge.sv
//**********************************************************************
// Top level of the SPI to RAM bridge
// The host reaches the RAM only through the SPI pins; stall tells it
// when the next frame may begin
//**********************************************************************
`timescale 1ns/10ps

module spi_ram_bridge (
    input  logic spi_cs_ni,  // System clock
    input  logic spi_sck_i,  // Async reset, active high
    input  logic sclk_i,
    input  logic csn_i,
    input  logic sd_i,
    output logic sd_o,
    output logic stall_o
);
    import spi_bridge_pkg::*;

    logic              rise, fall, sel, byte_done;
    spi_byte_u         rx_byte;
    logic              req_valid;
    bus_req_s          req, bus;
    logic              cyc, stb, ack;
    logic [DATA_W-1:0] ram_rdata, tx_data;
    logic              tx_load;

    spi_bit_counter u_bit_counter (
        .spi_cs_ni, .spi_sck_i, .sclk_i, .csn_i,
        .rise_o(rise), .fall_o(fall), .sel_o(sel), .byte_done_o(byte_done));

    spi_shifter u_shifter (
        .spi_cs_ni, .spi_sck_i, .sd_i,
        .rise_i(rise), .fall_i(fall), .sel_i(sel),
        .tx_load_i(tx_load), .tx_data_i(tx_data),
        .rx_byte_o(rx_byte), .sd_o);

    spi_cmd_fsm u_cmd_fsm (
        .spi_cs_ni, .spi_sck_i, .sel_i(sel), .byte_done_i(byte_done),
        .rx_byte_i(rx_byte), .req_valid_o(req_valid), .req_o(req));

    wb_requester u_requester (
        .spi_cs_ni, .spi_sck_i, .sel_i(sel),
        .req_valid_i(req_valid), .req_i(req),
        .ack_i(ack), .rdata_i(ram_rdata),
        .cyc_o(cyc), .stb_o(stb), .bus_o(bus),
        .tx_load_o(tx_load), .rdata_o(tx_data), .stall_o);

    bridge_ram u_ram (
        .spi_cs_ni, .spi_sck_i, .cyc_i(cyc), .stb_i(stb), .bus_i(bus),
        .ack_o(ack), .rdata_o(ram_rdata));

endmodule

//--- source/spi_shifter.sv
//**********************************************************************
// Serial shift registers for mode 0, MSB first
// Receives host bits on sclk rise and sends the latched read byte
// back during the command byte of the following frame
//**********************************************************************
`timescale 1ns/10ps

module spi_shifter (
    input  logic                                spi_cs_ni,
    input  logic                                spi_sck_i,
    input  logic                                sd_i,       // Host to bridge
    input  logic                                rise_i,
    input  logic                                fall_i,
    input  logic                                sel_i,
    input  logic                                tx_load_i,  // Read data strobe
    input  logic [spi_bridge_pkg::DATA_W-1:0]   tx_data_i,
    output spi_bridge_pkg::spi_byte_u           rx_byte_o,  // Valid with byte_done
    output logic                                sd_o        // Bridge to host
);
    import spi_bridge_pkg::*;

    logic [SYNC_STAGES-1:0] sd_sync;  // Matches the sclk synchroniser delay
    logic [DATA_W-1:0]      rx_sr;
    logic [DATA_W-1:0]      tx_sr;
    logic [DATA_W-1:0]      tx_latch; // Last read result
    logic                   sel_q;

    always_ff @(posedge spi_cs_ni) begin
        sd_sync <= {sd_sync[SYNC_STAGES-2:0], sd_i};
        if (rise_i) begin
            rx_sr <= {rx_sr[DATA_W-2:0], sd_sync[SYNC_STAGES-1]};
        end
    end

    // Includes the bit arriving on this rise
    assign rx_byte_o.raw = {rx_sr[DATA_W-2:0], sd_sync[SYNC_STAGES-1]};

    always_ff @(posedge spi_cs_ni or posedge spi_sck_i) begin
        if (spi_sck_i) begin
            tx_latch <= '0;
            tx_sr    <= '0;
            sel_q    <= 1'b0;
        end else begin
            sel_q <= sel_i;
            if (tx_load_i) tx_latch <= tx_data_i;
            if (sel_i && !sel_q) begin
                tx_sr <= tx_latch;  // Frame start, MSB goes out at once
            end else if (fall_i) begin
                tx_sr <= {tx_sr[DATA_W-2:0], 1'b0};
            end
        end
    end

    assign sd_o = tx_sr[DATA_W-1];

endmodule

//--- source/wb_requester.sv
//**********************************************************************
// Bus master side of the bridge
// Turns each request into one strobe, holds cycle until ack and
// returns read data to the transmit latch; stall covers the frame
//**********************************************************************
`timescale 1ns/10ps

module wb_requester (
    input  logic                                spi_cs_ni,
    input  logic                                spi_sck_i,
    input  logic                                sel_i,
    input  logic                                req_valid_i,
    input  spi_bridge_pkg::bus_req_s            req_i,
    input  logic                                ack_i,
    input  logic [spi_bridge_pkg::DATA_W-1:0]   rdata_i,
    output logic                                cyc_o,
    output logic                                stb_o,
    output spi_bridge_pkg::bus_req_s            bus_o,
    output logic                                tx_load_o,  // One cycle after a read ack
    output logic [spi_bridge_pkg::DATA_W-1:0]   rdata_o,
    output logic                                stall_o
);
    typedef enum logic [1:0] {wb_idle, wb_rx, wb_wait} wb_state_e;

    wb_state_e state;
    logic      sel_q;  // Frame start detect

    always_ff @(posedge spi_cs_ni or posedge spi_sck_i) begin
        if (spi_sck_i) begin
            state     <= wb_idle;
            sel_q     <= 1'b0;
            cyc_o     <= 1'b0;
            stb_o     <= 1'b0;
            tx_load_o <= 1'b0;
        end else begin
            sel_q     <= sel_i;
            stb_o     <= 1'b0;
            tx_load_o <= 1'b0;
            unique case (state)
                wb_idle: if (sel_i && !sel_q) state <= wb_rx;
                wb_rx: begin
                    if (!sel_i) begin
                        state <= wb_idle;  // Frame ended early, nothing to do
                    end else if (req_valid_i) begin
                        state <= wb_wait;
                        cyc_o <= 1'b1;
                        stb_o <= 1'b1;
                    end
                end
                wb_wait: begin
                    if (ack_i) begin
                        state     <= wb_idle;
                        cyc_o     <= 1'b0;
                        tx_load_o <= !bus_o.we;  // Writes keep the old read byte
                    end
                end
                default: state <= wb_idle;
            endcase
        end
    end

    always_ff @(posedge spi_cs_ni) begin
        if (state == wb_rx && req_valid_i) bus_o <= req_i;
        if (ack_i) rdata_o <= rdata_i;
    end

    assign stall_o = (state != wb_idle);

    a_stb_single_in_cyc: assert property (
        @(posedge spi_cs_ni) disable iff (spi_sck_i) stb_o |-> cyc_o ##1 !stb_o);

endmodule

//--- include/spi_host_tasks.svh
//**********************************************************************
// Host side SPI tasks for the bridge testbench
// Included inside the testbench module, which provides spi_cs_ni
// (clock), sclk, csn, sdi, sdo and stall; inputs move 1 ns after edges
//**********************************************************************
`ifndef SPI_HOST_TASKS_SVH
`define SPI_HOST_TASKS_SVH

localparam int SPI_HALF_CLKS = 6;  // System clocks per sclk half-period

task automatic spi_wait(input int n);
    repeat (n) @(posedge spi_cs_ni);
    #1;
endtask

// One byte in mode 0, MSB first, sdo sampled on the rising edge
task automatic spi_byte(input logic [7:0] tx, output logic [7:0] rx);
    for (int i = 7; i >= 0; i--) begin
        sdi = tx[i];
        spi_wait(SPI_HALF_CLKS);
        sclk  = 1'b1;
        rx[i] = sdo;
        spi_wait(SPI_HALF_CLKS);
        sclk = 1'b0;
    end
endtask

// Full frame, byte count follows the command bits
task automatic spi_frame(input logic [7:0] cmd, input logic [7:0] data,
                         input logic [7:0] addr_lo, output logic [7:0] rx_cmd);
    logic [7:0] rx_dummy;
    while (stall) spi_wait(1);
    csn = 1'b0;
    spi_wait(SPI_HALF_CLKS);
    spi_byte(cmd, rx_cmd);           // Previous read result comes back here
    if (cmd[7]) spi_byte(data, rx_dummy);
    if (cmd[6]) spi_byte(addr_lo, rx_dummy);
    spi_wait(2);
    while (stall) spi_wait(1);       // Bus cycle done
    csn = 1'b1;
    spi_wait(SPI_HALF_CLKS);
endtask

// Command byte only, then release, so no request is made
task automatic spi_abort(input logic [7:0] cmd);
    logic [7:0] rx_dummy;
    while (stall) spi_wait(1);
    csn = 1'b0;
    spi_wait(SPI_HALF_CLKS);
    spi_byte(cmd, rx_dummy);
    csn = 1'b1;
    spi_wait(SPI_HALF_CLKS);
endtask

`endif

//--- testbench/tb_spi_ram_bridge.sv
//**********************************************************************
// Testbench for the SPI to RAM bridge
// Drives host frames through the SPI pins only and checks every byte
// that comes back against a reference memory model kept here
// Random frames use a fixed seed and repeat from run to run
//**********************************************************************
`timescale 1ns/10ps

module tb_spi_ram_bridge;
    import spi_bridge_pkg::*;

    localparam int N_FRAMES   = 332;   // Frames over all tests
    localparam int FRAME_NS   = 3200;  // Three bytes plus framing gaps
    localparam int TIMEOUT_NS = N_FRAMES * FRAME_NS + 20000;

    logic spi_cs_ni;  // System clock
    logic spi_sck_i;  // Reset
    logic sclk, csn, sdi;
    logic sdo, stall;

    logic [DATA_W-1:0] mem_model [2**ADDR_W];
    logic [ADDR_W-1:0] model_addr;    // Address of the last bus request
    logic [DATA_W-1:0] last_read;     // Byte the next frame returns
    int                errors, checks, tests, failed_tests;
    int                stall_cycles;  // Clocks with stall high inside a frame

    spi_ram_bridge uut (
        .spi_cs_ni, .spi_sck_i, .sclk_i(sclk), .csn_i(csn), .sd_i(sdi),
        .sd_o(sdo), .stall_o(stall));

    `include "spi_host_tasks.svh"

    always #5 spi_cs_ni = ~spi_cs_ni;

    always @(posedge spi_cs_ni) begin
        if (!csn && stall) stall_cycles <= stall_cycles + 1;
    end

    task automatic check_val(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("Error at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, exp, act);
        end
    endtask

    // One complete frame checked and mirrored into the model
    task automatic run_frame(input logic [7:0] cmd, input logic [7:0] data,
                             input logic [7:0] addr_lo);
        logic [7:0] rx;
        int         stall_before;
        check_val("stall_o", 0, 32'(stall));  // Idle before the frame
        stall_before = stall_cycles;
        spi_frame(cmd, data, addr_lo, rx);
        check_val("sd_o", 32'(last_read), 32'(rx));
        check_val("stall_o", 1, 32'(stall_cycles > stall_before));
        if (cmd[6]) begin
            model_addr = {cmd[3:0], addr_lo};
        end else begin
            model_addr = model_addr + 12'd1;  // Wraps at 4096
        end
        if (cmd[7]) begin
            mem_model[model_addr] = data;
        end else begin
            last_read = mem_model[model_addr];  // Comes back in the next frame
        end
    endtask

    task automatic write_at(input logic [11:0] addr, input logic [7:0] data);
        run_frame({2'b11, 2'b00, addr[11:8]}, data, addr[7:0]);
    endtask

    task automatic read_at(input logic [11:0] addr);
        run_frame({2'b01, 2'b00, addr[11:8]}, 8'h00, addr[7:0]);
    endtask

    task automatic write_next(input logic [7:0] data);
        run_frame(8'h80, data, 8'h00);
    endtask

    task automatic end_test(input string name, input int err_before);
        tests++;
        if (errors == err_before) begin
            $display("Test %0d %s: ok", tests, name);
        end else begin
            failed_tests++;
            $display("Test %0d %s: FAILED with %0d errors", tests, name, errors - err_before);
        end
    endtask

    // Watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the frames did not complete in the expected time");
        $display("Regression failed");
        $finish;
    end

    initial begin
        int          e0;
        logic [11:0] a;
        logic [7:0]  c, d, l;
        void'($urandom(39180));
        spi_cs_ni = 1'b0;
        spi_sck_i = 1'b1;
        sclk      = 1'b0;
        csn       = 1'b1;  // Deselected
        sdi       = 1'b0;
        model_addr = '0;
        last_read  = '0;
        for (int i = 0; i < 2**ADDR_W; i++) mem_model[i] = '0;
        repeat (2) @(posedge spi_cs_ni);
        #1 spi_sck_i = 1'b0;
        spi_wait(2);

        e0 = errors;
        check_val("stall_o", 0, 32'(stall));
        check_val("sd_o", 0, 32'(sdo));
        read_at(12'($urandom));
        read_at(12'hFFF);
        read_at(12'h000);
        end_test("reset state and zero reads", e0);

        e0 = errors;
        for (int i = 0; i < 4; i++) begin
            a = 12'($urandom);
            d = 8'($urandom);
            write_at(a, d);
            read_at(a);       // Checked by the next frame
        end
        write_at(12'h7A0, 8'h5E);
        end_test("write then read back", e0);

        e0 = errors;
        write_at(12'hFFD, 8'($urandom));
        for (int i = 0; i < 4; i++) write_next(8'($urandom));  // Lands at FFE up to 001
        read_at(12'hFFD);
        read_at(12'hFFE);
        read_at(12'hFFF);
        read_at(12'h000);
        read_at(12'h001);
        run_frame(8'h00, 8'h00, 8'h00);  // Read at 002 by increment
        end_test("address increment and wrap", e0);

        e0 = errors;
        for (int i = 0; i < 300; i++) begin
            c = 8'($urandom);
            d = 8'($urandom);
            l = 8'($urandom);
            run_frame(c, d, l);
        end
        read_at(12'h100);
        end_test("random frames", e0);

        e0 = errors;
        write_at(12'h2C4, 8'h3C);
        spi_abort(8'hC2);  // Write command with no data byte
        check_val("stall_o", 0, 32'(stall));
        spi_abort(8'h80);  // Write at the next address cut short
        check_val("stall_o", 0, 32'(stall));
        write_next(8'hA7);  // Lands at 2C5 only when no abort moved the address
        read_at(12'h2C4);
        read_at(12'h2C5);
        read_at(12'h2C6);   // Untouched by the aborted writes
        read_at(12'h000);
        end_test("stall and aborted frames", e0);

        $display("Tests %0d, failed %0d, checks %0d, errors %0d",
                 tests, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule
